// File: Makefile
# Verilator build and run for the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sources.f
+incdir+verilog
verilog/core_pkg.sv
verilog/ctrl_unit.sv
verilog/idu.sv
verilog/reg_file.sv
verilog/exu.sv
verilog/pc_unit.sv
verilog/core_top.sv
test/core_tb.sv

// File: test/core_tb.sv
// rv32i core testbench
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int SLACK_CYCLES = 20;
    localparam int DRIVE_DELAY  = 1;

    // five hex words per trace line
    localparam int FIELDS      = 5;
    localparam int MAX_STEPS   = 100;
    localparam int TRACE_DEPTH = 512;
    localparam int IDX_W       = 9;

    localparam int F_PC   = 0;
    localparam int F_INST = 1;
    localparam int F_WE   = 2;
    localparam int F_ADDR = 3;
    localparam int F_DATA = 4;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] trace_mem [0:TRACE_DEPTH-1];
    int          num_steps;
    int          cycle_count = 0;
    int          cycle_limit = RESET_CYCLES + SLACK_CYCLES;

    core_top DUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .inst_i    (inst),
        .pc_o      (pc),
        .wb_en_o   (wb_en),
        .wb_addr_o (wb_addr),
        .wb_data_o (wb_data)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ----------------------------------------
    // run limit
    // ----------------------------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // one word of one trace line
    function automatic logic [31:0] trace_field(input int step, input int field);
        return trace_mem[IDX_W'(step * FIELDS + field)];
    endfunction

    // lines end where the enable column no longer holds 0 or 1
    function automatic int count_steps();
        int n;
        n = 0;
        while ((n < MAX_STEPS) && (trace_field(n, F_WE) <= 32'd1)) begin
            n++;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ----------------------------------------
    // stimulus and checks
    // ----------------------------------------
    initial begin
        int step;
        clk   = 1'b0;
        rst_n = 1'b0;
        // a writing addi, held back by reset
        inst  = 32'h0010_0093;

        for (int i = 0; i < TRACE_DEPTH; i++) begin
            trace_mem[IDX_W'(i)] = 32'hE000_0000 | 32'(i);
        end
        $readmemh("test/core_trace.txt", trace_mem);
        num_steps = count_steps();
        if (num_steps == 0) begin
            $display("no instruction lines were read from the trace file");
            $display("RESULT: FAIL");
            $fatal(1, "empty trace");
        end
        cycle_limit = num_steps + RESET_CYCLES + SLACK_CYCLES;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_value("wb_en_o", 32'(wb_en), 32'd0);
        end
        rst_n = 1'b1;

        // one instruction per cycle checked at the falling edge
        for (step = 0; step < num_steps; step++) begin
            inst = trace_field(step, F_INST);
            @(negedge clk);
            check_value("pc_o", pc, trace_field(step, F_PC));
            check_value("wb_en_o", 32'(wb_en), trace_field(step, F_WE));
            if (trace_field(step, F_WE) == 32'd1) begin
                check_value("wb_addr_o", 32'(wb_addr), trace_field(step, F_ADDR));
                check_value("wb_data_o", wb_data, trace_field(step, F_DATA));
            end
            @(posedge clk);
            #(DRIVE_DELAY);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/core_trace.txt
// columns: pc, instruction, write enable, rd, write data (all hex)
// one line per executed instruction, skipped slots are never fetched
80000000 800000B7 1 01 80000000 // lui   x1, 0x80000
80000004 FFB00113 1 02 FFFFFFFB // addi  x2, x0, -5
80000008 00700193 1 03 00000007 // addi  x3, x0, 7
8000000C 00310233 1 04 00000002 // add   x4, x2, x3
80000010 402182B3 1 05 0000000C // sub   x5, x3, x2
80000014 00312333 1 06 00000001 // slt   x6, x2, x3
80000018 003133B3 1 07 00000000 // sltu  x7, x2, x3
8000001C 4030D433 1 08 FF000000 // sra   x8, x1, x3
80000020 0030D4B3 1 09 01000000 // srl   x9, x1, x3
80000024 00319533 1 0A 00000380 // sll   x10, x3, x3
80000028 003145B3 1 0B FFFFFFFC // xor   x11, x2, x3
8000002C 00316633 1 0C FFFFFFFF // or    x12, x2, x3
80000030 003176B3 1 0D 00000003 // and   x13, x2, x3
80000034 FFF1B713 1 0E 00000001 // sltiu x14, x3, -1
80000038 40115793 1 0F FFFFFFFD // srai  x15, x2, 1
8000003C FFC12813 1 10 00000001 // slti  x16, x2, -4
80000040 12345897 1 11 92345040 // auipc x17, 0x12345
80000044 00518013 0 00 00000000 // addi  x0, x3, 5
80000048 00300933 1 12 00000007 // add   x18, x0, x3
8000004C 00310463 0 00 00000000 // beq   x2, x3, +8 not taken
80000050 01218463 0 00 00000000 // beq   x3, x18, +8 taken
80000058 01219463 0 00 00000000 // bne   x3, x18, +8 not taken
8000005C 00311463 0 00 00000000 // bne   x2, x3, +8 taken
80000064 0021C463 0 00 00000000 // blt   x3, x2, +8 not taken
80000068 00314463 0 00 00000000 // blt   x2, x3, +8 taken
80000070 00315463 0 00 00000000 // bge   x2, x3, +8 not taken
80000074 0021D463 0 00 00000000 // bge   x3, x2, +8 taken
8000007C 00316463 0 00 00000000 // bltu  x2, x3, +8 not taken
80000080 0021E463 0 00 00000000 // bltu  x3, x2, +8 taken
80000088 0021F463 0 00 00000000 // bgeu  x3, x2, +8 not taken
8000008C 00317463 0 00 00000000 // bgeu  x2, x3, +8 taken
80000094 010009EF 1 13 80000098 // jal   x19, +16
800000A4 01998A67 1 14 800000A8 // jalr  x20, 0x19(x19)
800000B0 413A0AB3 1 15 00000010 // sub   x21, x20, x19
800000B4 ABCDE037 0 00 00000000 // lui   x0, 0xABCDE
800000B8 00100B33 1 16 80000000 // add   x22, x0, x1

// File: verilog/core_config.svh
// core build parameters
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// register and pc width
`define CORE_DATA_WIDTH 32

// register index width for 32 architectural registers
`define CORE_REG_ADDR_WIDTH 5

// ----------------------------------------
// fetch
// ----------------------------------------

// first instruction address after reset
`define CORE_RESET_PC 32'h8000_0000

`endif

// File: verilog/core_pkg.sv
// core shared types
`default_nettype none

`include "core_config.svh"

package core_pkg;

    // ----------------------------------------
    // plain vectors
    // ----------------------------------------
    typedef logic [`CORE_DATA_WIDTH-1:0]     word_t;
    typedef logic [`CORE_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // ----------------------------------------
    // decode selects
    // ----------------------------------------
    // code 2'b10 of op2 is left free
    typedef enum logic [1:0] {
        OP1_RS1 = 2'b00,
        OP1_IMU = 2'b01
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_IMI = 2'b00,
        OP2_PC  = 2'b01,
        OP2_RS2 = 2'b11
    } op2_sel_e;

    // pass-first-operand serves lui
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_COPY1 = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_PLUS4 = 2'd0,
        PC_BR    = 2'd1,
        PC_JAL   = 2'd2,
        PC_JALR  = 2'd3
    } pc_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_type_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_PC4 = 1'b1
    } wb_sel_e;

endpackage

`default_nettype wire

// File: verilog/core_top.sv
// single-cycle rv32i core
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  core_pkg::word_t     inst_i,
    output core_pkg::word_t     pc_o,
    output logic                wb_en_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::word_t     wb_data_o
);

    import core_pkg::*;

    // ----------------------------------------
    // control selects
    // ----------------------------------------
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    alu_op_e   alu_op;
    pc_sel_e   pc_sel;
    br_type_e  br_type;
    wb_sel_e   wb_sel;
    logic      rd_we;

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op1;
    word_t     op2;
    word_t     br_target;
    word_t     jmp_target;
    word_t     jump_reg_target;
    logic      br_eq;
    logic      br_lt;
    logic      br_ltu;
    word_t     pc;
    word_t     pc_plus4;
    word_t     wb_data;

    ctrl_unit u_ctrl (
        .rst_n_i   (rst_n_i),
        .inst_i    (inst_i),
        .op1_sel_o (op1_sel),
        .op2_sel_o (op2_sel),
        .alu_op_o  (alu_op),
        .pc_sel_o  (pc_sel),
        .br_type_o (br_type),
        .wb_sel_o  (wb_sel),
        .rd_we_o   (rd_we)
    );

    idu u_idu (
        .inst_i            (inst_i),
        .pc_i              (pc),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .op1_sel_i         (op1_sel),
        .op2_sel_i         (op2_sel),
        .rs1_addr_o        (rs1_addr),
        .rs2_addr_o        (rs2_addr),
        .rd_addr_o         (rd_addr),
        .op1_o             (op1),
        .op2_o             (op2),
        .br_target_o       (br_target),
        .jmp_target_o      (jmp_target),
        .jump_reg_target_o (jump_reg_target),
        .br_eq_o           (br_eq),
        .br_lt_o           (br_lt),
        .br_ltu_o          (br_ltu)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rd_we),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (wb_data)
    );

    exu u_exu (
        .op1_i      (op1),
        .op2_i      (op2),
        .alu_op_i   (alu_op),
        .wb_sel_i   (wb_sel),
        .pc_plus4_i (pc_plus4),
        .wb_data_o  (wb_data)
    );

    pc_unit u_pc (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .pc_sel_i          (pc_sel),
        .br_type_i         (br_type),
        .br_eq_i           (br_eq),
        .br_lt_i           (br_lt),
        .br_ltu_i          (br_ltu),
        .br_target_i       (br_target),
        .jmp_target_i      (jmp_target),
        .jump_reg_target_i (jump_reg_target),
        .pc_o              (pc),
        .pc_plus4_o        (pc_plus4)
    );

    // write-back port mirrors the register write
    assign pc_o      = pc;
    assign wb_en_o   = rd_we;
    assign wb_addr_o = rd_addr;
    assign wb_data_o = wb_data;

endmodule

`default_nettype wire

// File: verilog/ctrl_unit.sv
// instruction control decode
`timescale 1ns/1ps
`default_nettype none

module ctrl_unit (
    input  wire                 rst_n_i,
    input  core_pkg::word_t     inst_i,
    output core_pkg::op1_sel_e  op1_sel_o,
    output core_pkg::op2_sel_e  op2_sel_o,
    output core_pkg::alu_op_e   alu_op_o,
    output core_pkg::pc_sel_e   pc_sel_o,
    output core_pkg::br_type_e  br_type_o,
    output core_pkg::wb_sel_e   wb_sel_o,
    output logic                rd_we_o
);

    import core_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    reg_addr_t  rd;
    alu_op_e    alu_f3;
    logic       wr_req;

    assign opcode    = inst_i[6:0];
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];
    assign rd        = inst_i[11:7];

    // ----------------------------------------
    // alu op from funct3
    // ----------------------------------------
    // bit 30 means sub only for register ops; addi ignores it
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (funct7_b5 && (opcode == OPC_OP)) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_f3 = ALU_SLL;
            3'b010:  alu_f3 = ALU_SLT;
            3'b011:  alu_f3 = ALU_SLTU;
            3'b100:  alu_f3 = ALU_XOR;
            3'b101:  alu_f3 = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    // ----------------------------------------
    // opcode decode
    // ----------------------------------------
    always_comb begin
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
        alu_op_o  = ALU_ADD;
        pc_sel_o  = PC_PLUS4;
        br_type_o = BR_NONE;
        wb_sel_o  = WB_ALU;
        wr_req    = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op_o = alu_f3;
                wr_req   = 1'b1;
            end
            OPC_OP_IMM: begin
                op2_sel_o = OP2_IMI;
                alu_op_o  = alu_f3;
                wr_req    = 1'b1;
            end
            OPC_LUI: begin
                op1_sel_o = OP1_IMU;
                alu_op_o  = ALU_COPY1;
                wr_req    = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel_o = OP1_IMU;
                op2_sel_o = OP2_PC;
                wr_req    = 1'b1;
            end
            OPC_JAL: begin
                pc_sel_o = PC_JAL;
                wb_sel_o = WB_PC4;
                wr_req   = 1'b1;
            end
            OPC_JALR: begin
                pc_sel_o = PC_JALR;
                wb_sel_o = WB_PC4;
                wr_req   = 1'b1;
            end
            OPC_BRANCH: begin
                pc_sel_o = PC_BR;
                case (funct3)
                    3'b000:  br_type_o = BR_EQ;
                    3'b001:  br_type_o = BR_NE;
                    3'b100:  br_type_o = BR_LT;
                    3'b101:  br_type_o = BR_GE;
                    3'b110:  br_type_o = BR_LTU;
                    3'b111:  br_type_o = BR_GEU;
                    default: br_type_o = BR_NONE;
                endcase
            end
            // anything else falls through as a no-op
            default: ;
        endcase
    end

    // x0 is never written, nor anything while in reset
    assign rd_we_o = wr_req && (rd != '0) && rst_n_i;

endmodule

`default_nettype wire

// File: verilog/exu.sv
// execute unit
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module exu (
    input  core_pkg::word_t    op1_i,
    input  core_pkg::word_t    op2_i,
    input  core_pkg::alu_op_e  alu_op_i,
    input  core_pkg::wb_sel_e  wb_sel_i,
    input  core_pkg::word_t    pc_plus4_i,
    output core_pkg::word_t    wb_data_o
);

    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`CORE_DATA_WIDTH);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;
    word_t              alu_res;

    assign shamt = op2_i[SHAMT_W-1:0];
    assign lt_s  = ($signed(op1_i) < $signed(op2_i));
    assign lt_u  = (op1_i < op2_i);

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_res = op1_i + op2_i;
            ALU_SUB:   alu_res = op1_i - op2_i;
            ALU_SLL:   alu_res = op1_i << shamt;
            ALU_SLT:   alu_res = {{(`CORE_DATA_WIDTH-1){1'b0}}, lt_s};
            ALU_SLTU:  alu_res = {{(`CORE_DATA_WIDTH-1){1'b0}}, lt_u};
            ALU_XOR:   alu_res = op1_i ^ op2_i;
            ALU_SRL:   alu_res = op1_i >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:   alu_res = word_t'($signed(op1_i) >>> shamt);
            ALU_OR:    alu_res = op1_i | op2_i;
            ALU_AND:   alu_res = op1_i & op2_i;
            ALU_COPY1: alu_res = op1_i;
            default:   alu_res = '0;
        endcase
    end

    // ----------------------------------------
    // write-back select
    // ----------------------------------------
    // link address for jal and jalr
    assign wb_data_o = (wb_sel_i == WB_PC4) ? pc_plus4_i : alu_res;

endmodule

`default_nettype wire

// File: verilog/idu.sv
// instruction decode unit
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  core_pkg::word_t     inst_i,
    input  core_pkg::word_t     pc_i,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    input  core_pkg::op1_sel_e  op1_sel_i,
    input  core_pkg::op2_sel_e  op2_sel_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    output core_pkg::reg_addr_t rd_addr_o,
    output core_pkg::word_t     op1_o,
    output core_pkg::word_t     op2_o,
    output core_pkg::word_t     br_target_o,
    output core_pkg::word_t     jmp_target_o,
    output core_pkg::word_t     jump_reg_target_o,
    output logic                br_eq_o,
    output logic                br_lt_o,
    output logic                br_ltu_o
);

    import core_pkg::*;

    word_t imm_i;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // ----------------------------------------
    // register fields
    // ----------------------------------------
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // ----------------------------------------
    // immediates
    // ----------------------------------------
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // jalr clears bit 0 of its target
    assign br_target_o       = pc_i + imm_b;
    assign jmp_target_o      = pc_i + imm_j;
    assign jump_reg_target_o = (rs1_data_i + imm_i) & ~word_t'(1);

    // compare flags for pc_unit
    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

    // ----------------------------------------
    // operand select
    // ----------------------------------------
    always_comb begin
        case (op1_sel_i)
            OP1_IMU: op1_o = imm_u;
            default: op1_o = rs1_data_i;
        endcase
    end

    always_comb begin
        case (op2_sel_i)
            OP2_IMI: op2_o = imm_i;
            OP2_PC:  op2_o = pc_i;
            OP2_RS2: op2_o = rs2_data_i;
            default: op2_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/pc_unit.sv
// program counter unit
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module pc_unit (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  core_pkg::pc_sel_e   pc_sel_i,
    input  core_pkg::br_type_e  br_type_i,
    input  wire                 br_eq_i,
    input  wire                 br_lt_i,
    input  wire                 br_ltu_i,
    input  core_pkg::word_t     br_target_i,
    input  core_pkg::word_t     jmp_target_i,
    input  core_pkg::word_t     jump_reg_target_i,
    output core_pkg::word_t     pc_o,
    output core_pkg::word_t     pc_plus4_o
);

    import core_pkg::*;

    word_t pc_q;
    word_t pc_next;
    logic  br_taken;

    assign pc_plus4_o = pc_q + 32'd4;
    assign pc_o       = pc_q;

    // ne and ge are the inverted flags
    always_comb begin
        case (br_type_i)
            BR_EQ:   br_taken = br_eq_i;
            BR_NE:   br_taken = !br_eq_i;
            BR_LT:   br_taken = br_lt_i;
            BR_GE:   br_taken = !br_lt_i;
            BR_LTU:  br_taken = br_ltu_i;
            BR_GEU:  br_taken = !br_ltu_i;
            default: br_taken = 1'b0;
        endcase
    end

    // ----------------------------------------
    // next pc
    // ----------------------------------------
    always_comb begin
        case (pc_sel_i)
            PC_BR:   pc_next = br_taken ? br_target_i : pc_plus4_o;
            PC_JAL:  pc_next = jmp_target_i;
            PC_JALR: pc_next = jump_reg_target_i;
            default: pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `CORE_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// integer register file
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    input  wire                 we_i,
    input  core_pkg::reg_addr_t rd_addr_i,
    input  core_pkg::word_t     rd_data_i
);

    import core_pkg::*;

    localparam int NUM_REGS = 2 ** `CORE_REG_ADDR_WIDTH;

    // x0 has no storage
    word_t regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    // ----------------------------------------
    // read ports with x0 hardwired
    // ----------------------------------------
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire
